// File: compile.f
logic/gameDataPkg.sv
logic/gameCtrlPkg.sv
logic/playDecode.sv
logic/gameControl.sv
logic/gameDatapath.sv
logic/gameResult.sv
logic/memoryGameTop.sv
bench/memoryGame_chk.sv
bench/memoryGameTb.sv

// File: runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module memoryGameTb -f compile.f \
    -Mdir obj_dir -o memoryGameSim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/memoryGameSim > sim.log 2>&1

grep -qx "sim passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: bench/memoryGameTb.sv
/*
 * Testbench for memoryGameTop with short show and play times.
 * Scenario rows are played in order, each game started from the end
 * state of the previous one. Outputs are sampled on the falling edge.
 */
`timescale 1ns/1ps

module memoryGameTb;

    localparam int showTicks  = 4;
    localparam int playTicks  = 20;
    localparam int numRows    = 6;
    localparam int roundBound = 16 * (showTicks + 3) + 16 * (playTicks + 16) + 8;
    localparam int turnLimit  = 16 * (showTicks + 3) + playTicks + 16;
    localparam int endLimit   = playTicks + 16;

    localparam logic [1:0] actNone  = 2'd0;
    localparam logic [1:0] actWrong = 2'd1;
    localparam logic [1:0] actHold  = 2'd2;

    // Reference sequence of the game
    localparam gameDataPkg::keyCode refSeq [16] = '{
        2'd0, 2'd1, 2'd2, 2'd3, 2'd2, 2'd1, 2'd0, 2'd3,
        2'd1, 2'd1, 2'd2, 2'd2, 2'd3, 2'd0, 2'd0, 2'd3
    };

    typedef struct packed {
        logic                tempo;
        logic                jogadas;
        logic [1:0]          action;
        logic [3:0]          atRound;
        logic [3:0]          atEntry;
        gameCtrlPkg::outcome expected;
    } scenario;

    logic                  clock;
    logic                  reset;
    logic                  iniciar;
    logic                  nivelTempo;
    logic                  nivelJogadas;
    logic [3:0]            buttons;
    logic [3:0]            leds;
    logic                  acertou;
    logic                  errou;
    logic                  timeout;
    logic                  pronto;
    logic                  vezJogador;
    gameCtrlPkg::gameState dbState;

    scenario scenarios [numRows];
    int      errorCount;
    int      waitErrors;
    logic    wasShowing;
    int      shownIdx;
    int      showsThisRound;
    int      roundNum;

    memoryGameTop #(
        .showTicks (showTicks),
        .playTicks (playTicks)
    ) DUT (
        .clock        (clock),
        .reset        (reset),
        .iniciar      (iniciar),
        .nivelTempo   (nivelTempo),
        .nivelJogadas (nivelJogadas),
        .buttons      (buttons),
        .leds         (leds),
        .acertou      (acertou),
        .errou        (errou),
        .timeout      (timeout),
        .pronto       (pronto),
        .vezJogador   (vezJogador),
        .dbState      (dbState)
    );

    bind memoryGameTop memoryGameChk chk (
        .clock      (clock),
        .reset      (reset),
        .iniciar    (iniciar),
        .acertou    (acertou),
        .errou      (errou),
        .timeout    (timeout),
        .pronto     (pronto),
        .vezJogador (vezJogador)
    );

    always #20 clock = ~clock;

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic checkLeds(input logic [3:0] expected, input string what);
        if (leds !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t: %s leds expected %b, got %b",
                     $time, what, expected, leds);
        end
    endtask

    task automatic checkFlag(input logic seen, input logic expected, input string what);
        if (seen !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, what, expected, seen);
        end
    endtask

    task automatic checkState(input gameCtrlPkg::gameState expected, input string what);
        if (dbState !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t: %s state expected %s, got %s",
                     $time, what, expected.name(), dbState.name());
        end
    endtask

    task automatic checkOutcome(input gameCtrlPkg::outcome expected, input string what);
        gameCtrlPkg::outcome seen;
        logic [2:0]          flags;
        flags = {acertou, errou, timeout};
        case (flags)
            3'b000:  seen = gameCtrlPkg::none;
            3'b100:  seen = gameCtrlPkg::win;
            3'b010:  seen = gameCtrlPkg::loss;
            3'b001:  seen = gameCtrlPkg::timeout;
            default: seen = gameCtrlPkg::none;
        endcase
        if (flags != 3'b000 && seen == gameCtrlPkg::none) begin
            errorCount++;
            $display("MISMATCH at %0t: %s outcome flags %b are not a valid outcome",
                     $time, what, flags);
        end else if (seen != expected) begin
            errorCount++;
            $display("MISMATCH at %0t: %s outcome expected %s, got %s",
                     $time, what, expected.name(), seen.name());
        end
        checkFlag(pronto, expected != gameCtrlPkg::none, {what, " pronto"});
    endtask

    // --------------------------------------------------
    // Stimulus tasks
    // --------------------------------------------------
    task automatic waitTurn(output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < turnLimit && !ok; n++) begin
            @(negedge clock);
            ok = vezJogador;
        end
        if (!ok) begin
            waitErrors++;
            $display("No player turn came within %0d cycles, at %0t", turnLimit, $time);
        end
    endtask

    task automatic waitEnd(output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < endLimit && !ok; n++) begin
            @(negedge clock);
            ok = pronto;
        end
        if (!ok) begin
            waitErrors++;
            $display("The game did not end within %0d cycles, at %0t", endLimit, $time);
        end
    endtask

    // Key held two cycles and released two cycles while LEDs echo it
    task automatic pressKey(input gameDataPkg::keyCode code);
        @(posedge clock);
        buttons <= 4'b0001 << code;
        @(posedge clock);
        @(negedge clock);
        checkLeds(4'b0001 << code, "button echo");
        @(posedge clock);
        buttons <= 4'b0000;
        repeat (2) @(posedge clock);
    endtask

    task automatic startGame(input logic tempo, input logic jogadas);
        @(posedge clock);
        nivelTempo   <= tempo;
        nivelJogadas <= jogadas;
        iniciar      <= 1'b1;
        @(posedge clock);
        iniciar <= 1'b0;
        @(negedge clock);
        checkOutcome(gameCtrlPkg::none, "after start");
        checkState(gameCtrlPkg::initGame, "after start");
    endtask

    task automatic playGame(input scenario row);
        int                  rounds;
        int                  r;
        int                  e;
        logic                stop;
        logic                ok;
        logic                press;
        logic [3:0]          endLeds;
        gameDataPkg::keyCode code;
        rounds  = row.jogadas ? 16 : 4;
        stop    = 1'b0;
        endLeds = (row.expected == gameCtrlPkg::win) ? 4'b1111 : 4'b1010;
        startGame(row.tempo, row.jogadas);
        for (r = 0; r < rounds && !stop; r++) begin
            for (e = 0; e <= r && !stop; e++) begin
                waitTurn(ok);
                if (!ok) begin
                    stop = 1'b1;
                end else begin
                    code  = refSeq[e[3:0]];
                    press = 1'b1;
                    if (r == int'(row.atRound) && e == int'(row.atEntry)) begin
                        if (row.action == actWrong) begin
                            // Next key code is always a wrong one
                            code = code + 2'd1;
                            stop = 1'b1;
                        end else if (row.action == actHold && row.tempo) begin
                            press = 1'b0;
                            stop  = 1'b1;
                        end else if (row.action == actHold) begin
                            repeat (playTicks + 10) @(negedge clock);
                            checkFlag(vezJogador, 1'b1, "untimed wait vezJogador");
                            checkOutcome(gameCtrlPkg::none, "untimed wait");
                        end
                    end
                    if (press) begin
                        pressKey(code);
                    end
                end
            end
        end
        waitEnd(ok);
        checkOutcome(row.expected, "end of game");
        @(negedge clock);
        checkLeds(endLeds, "end pattern");
    endtask

    // --------------------------------------------------
    // Show order and turn monitor
    // --------------------------------------------------
    always @(negedge clock) begin
        if (!reset) begin
            // LEDs lag the show state by one cycle
            if (wasShowing) begin
                checkLeds(4'b0001 << refSeq[shownIdx[3:0]], "show order");
            end
            wasShowing = 1'b0;
            case (dbState)
                gameCtrlPkg::initGame: roundNum = -1;
                gameCtrlPkg::roundStart: begin
                    roundNum       = roundNum + 1;
                    showsThisRound = 0;
                end
                gameCtrlPkg::showEntry: begin
                    shownIdx       = showsThisRound;
                    showsThisRound = showsThisRound + 1;
                    wasShowing     = 1'b1;
                end
                gameCtrlPkg::showWait: wasShowing = 1'b1;
                default: ;
            endcase
            if (vezJogador && showsThisRound != roundNum + 1) begin
                errorCount++;
                $display("MISMATCH at %0t: player turn after %0d shows in round %0d",
                         $time, showsThisRound, roundNum);
            end
        end
    end

    // Upper bound for all rows at 16 rounds each
    initial begin
        repeat (numRows * 16 * roundBound) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the run did not finish",
                 numRows * 16 * roundBound);
        $display("sim failed");
        $finish;
    end

    initial begin
        int i;
        clock          = 1'b0;
        reset          = 1'b1;
        iniciar        = 1'b0;
        nivelTempo     = 1'b0;
        nivelJogadas   = 1'b0;
        buttons        = 4'b0000;
        errorCount     = 0;
        waitErrors     = 0;
        wasShowing     = 1'b0;
        shownIdx       = 0;
        showsThisRound = 0;
        roundNum       = -1;
        // tempo, jogadas, action, round, entry, outcome
        scenarios[0] = '{1'b0, 1'b0, actNone,  4'd0, 4'd0, gameCtrlPkg::win};
        scenarios[1] = '{1'b0, 1'b0, actWrong, 4'd2, 4'd1, gameCtrlPkg::loss};
        scenarios[2] = '{1'b1, 1'b0, actHold,  4'd1, 4'd0, gameCtrlPkg::timeout};
        scenarios[3] = '{1'b0, 1'b0, actHold,  4'd1, 4'd1, gameCtrlPkg::win};
        scenarios[4] = '{1'b1, 1'b1, actNone,  4'd0, 4'd0, gameCtrlPkg::win};
        scenarios[5] = '{1'b0, 1'b0, actWrong, 4'd0, 4'd0, gameCtrlPkg::loss};
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        for (i = 0; i < numRows; i++) begin
            playGame(scenarios[i]);
        end
        $display("Checks done: %0d mismatches, %0d wait timeouts", errorCount, waitErrors);
        if (errorCount == 0 && waitErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: bench/memoryGame_chk.sv
/*
 * Concurrent checks on the outcome outputs of memoryGameTop.
 * Bound to every memoryGameTop instance; reports only by $error.
 * All rules are disabled while reset is high.
 */
`timescale 1ns/1ps

module memoryGameChk (
    input logic clock,
    input logic reset,
    input logic iniciar,
    input logic acertou,
    input logic errou,
    input logic timeout,
    input logic pronto,
    input logic vezJogador
);

    // --------------------------------------------------
    // Outcome flags
    // --------------------------------------------------
    prontoIsAnyOutcome: assert property (@(posedge clock) disable iff (reset)
        pronto == (acertou || errou || timeout))
        else $error("pronto does not match the outcome flags");

    singleOutcome: assert property (@(posedge clock) disable iff (reset)
        $onehot0({acertou, errou, timeout}))
        else $error("more than one outcome flag is high");

    // Player turn never overlaps a finished game
    noTurnAfterEnd: assert property (@(posedge clock) disable iff (reset)
        !(vezJogador && pronto))
        else $error("vezJogador is high while pronto is high");

    // End state held until the next start strobe
    outcomeHeld: assert property (@(posedge clock) disable iff (reset)
        (pronto && !iniciar) |=> (pronto && $stable({acertou, errou, timeout})))
        else $error("outcome changed without iniciar");

endmodule

// File: logic/memoryGameTop.sv
/*
 * Sequence-memory game top level. Buttons must be debounced and
 * synchronous to clock. showTicks sets cycles per shown entry (held
 * showTicks+2 cycles), playTicks the cycles allowed per play.
 */
`timescale 1ns/1ps

module memoryGameTop #(
    parameter int showTicks = 1000,
    parameter int playTicks = 5000
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  iniciar,
    input  logic                  nivelTempo,
    input  logic                  nivelJogadas,
    input  logic [3:0]            buttons,
    output logic [3:0]            leds,
    output logic                  acertou,
    output logic                  errou,
    output logic                  timeout,
    output logic                  pronto,
    output logic                  vezJogador,
    output gameCtrlPkg::gameState dbState
);

    gameDataPkg::keyEvent  keyEvt;
    gameCtrlPkg::ctrlBus   ctrl;
    gameCtrlPkg::statusBus status;
    gameCtrlPkg::outcome   endCode;
    gameDataPkg::keyCode   showCode;
    logic                  showing;
    logic                  playerTurn;

    playDecode decode (
        .clock   (clock),
        .reset   (reset),
        .buttons (buttons),
        .key     (keyEvt)
    );

    gameControl control (
        .clock      (clock),
        .reset      (reset),
        .iniciar    (iniciar),
        .status     (status),
        .key        (keyEvt),
        .ctrl       (ctrl),
        .showing    (showing),
        .playerTurn (playerTurn),
        .endCode    (endCode),
        .dbState    (dbState)
    );

    gameDatapath #(
        .showTicks (showTicks),
        .playTicks (playTicks)
    ) execute (
        .clock        (clock),
        .reset        (reset),
        .ctrl         (ctrl),
        .key          (keyEvt),
        .nivelTempo   (nivelTempo),
        .nivelJogadas (nivelJogadas),
        .status       (status),
        .showCode     (showCode)
    );

    gameResult result (
        .clock      (clock),
        .reset      (reset),
        .showing    (showing),
        .playerTurn (playerTurn),
        .showCode   (showCode),
        .buttons    (buttons),
        .endCode    (endCode),
        .leds       (leds),
        .acertou    (acertou),
        .errou      (errou),
        .timeout    (timeout),
        .pronto     (pronto),
        .vezJogador (vezJogador)
    );

endmodule

// File: logic/gameResult.sv
/*
 * Outcome flags and LED drive. Flags and pronto decode endCode with no
 * register; the LED register lags its inputs by one cycle.
 * LED priority: show, then button echo, then end pattern.
 */
`timescale 1ns/1ps

module gameResult (
    input  logic                clock,
    input  logic                reset,
    input  logic                showing,
    input  logic                playerTurn,
    input  gameDataPkg::keyCode showCode,
    input  logic [3:0]          buttons,
    input  gameCtrlPkg::outcome endCode,
    output logic [3:0]          leds,
    output logic                acertou,
    output logic                errou,
    output logic                timeout,
    output logic                pronto,
    output logic                vezJogador
);

    logic [3:0] ledNext;

    always_comb begin
        if (showing) begin
            ledNext = 4'b0001 << showCode;
        end else if (playerTurn) begin
            ledNext = buttons;
        end else begin
            unique case (endCode)
                gameCtrlPkg::win:     ledNext = 4'b1111;
                gameCtrlPkg::loss,
                gameCtrlPkg::timeout: ledNext = 4'b1010;
                default:              ledNext = 4'b0000;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            leds <= 4'b0000;
        end else begin
            leds <= ledNext;
        end
    end

    assign acertou    = (endCode == gameCtrlPkg::win);
    assign errou      = (endCode == gameCtrlPkg::loss);
    assign timeout    = (endCode == gameCtrlPkg::timeout);
    assign pronto     = (endCode != gameCtrlPkg::none);
    assign vezJogador = playerTurn;

endmodule

// File: logic/gameDatapath.sv
/*
 * Game datapath: counters, fixed sequence table, play register, levels.
 * Counters update one cycle after their command. showDone rises at
 * showTicks, timeUp at playTicks; the play timer saturates there.
 */
`timescale 1ns/1ps

module gameDatapath #(
    parameter int showTicks = 1000,
    parameter int playTicks = 5000
) (
    input  logic                  clock,
    input  logic                  reset,
    input  gameCtrlPkg::ctrlBus   ctrl,
    input  gameDataPkg::keyEvent  key,
    input  logic                  nivelTempo,
    input  logic                  nivelJogadas,
    output gameCtrlPkg::statusBus status,
    output gameDataPkg::keyCode   showCode
);

    localparam int showWidth = $clog2(showTicks + 1);
    localparam int timeWidth = $clog2(playTicks + 1);

    gameDataPkg::seqAddr addr;
    gameDataPkg::seqAddr round;
    logic [showWidth-1:0] showCount;
    logic [timeWidth-1:0] timeCount;
    gameDataPkg::keyCode  playReg;
    gameDataPkg::keyCode  seqEntry;
    logic                 levelTimed;
    logic                 levelLong;

    // --------------------------------------------------
    // Counters and registers
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            addr       <= '0;
            round      <= '0;
            showCount  <= '0;
            timeCount  <= '0;
            playReg    <= '0;
            levelTimed <= 1'b0;
            levelLong  <= 1'b0;
        end else begin
            if (ctrl.zeroAddr) begin
                addr <= '0;
            end else if (ctrl.countAddr) begin
                addr <= addr + 4'd1;
            end
            if (ctrl.zeroRound) begin
                round <= '0;
            end else if (ctrl.countRound) begin
                round <= round + 4'd1;
            end
            if (ctrl.zeroShow) begin
                showCount <= '0;
            end else if (ctrl.countShow) begin
                showCount <= showCount + 1'b1;
            end
            if (ctrl.zeroTime) begin
                timeCount <= '0;
            end else if (ctrl.countTime && !status.timeUp) begin
                timeCount <= timeCount + 1'b1;
            end
            if (ctrl.zeroPlay) begin
                playReg <= '0;
            end else if (ctrl.loadPlay) begin
                playReg <= key.code;
            end
            if (ctrl.loadLevel) begin
                levelTimed <= nivelTempo;
                levelLong  <= nivelJogadas;
            end
        end
    end

    // Fixed sequence 0,1,2,3,2,1,0,3,1,1,2,2,3,0,0,3
    always_comb begin
        unique case (addr)
            4'd0, 4'd6, 4'd13, 4'd14:        seqEntry = 2'd0;
            4'd1, 4'd5, 4'd8, 4'd9:          seqEntry = 2'd1;
            4'd2, 4'd4, 4'd10, 4'd11:        seqEntry = 2'd2;
            default:                         seqEntry = 2'd3;
        endcase
    end

    assign showCode = seqEntry;

    // --------------------------------------------------
    // Status to the FSM
    // --------------------------------------------------
    assign status.showDone    = (showCount == showWidth'(showTicks));
    assign status.timeUp      = (timeCount == timeWidth'(playTicks));
    assign status.addrEqRound = (addr == round);
    assign status.lastRound   = (round == (levelLong ? 4'd15 : 4'd3));
    assign status.playCorrect = (playReg == seqEntry);
    assign status.timedLevel  = levelTimed;

endmodule

// File: logic/gameControl.sv
/*
 * Game control FSM (Moore). All commands and flags decode the state only.
 * Key events outside playWait are ignored. An end state holds until the
 * next iniciar strobe.
 */
`timescale 1ns/1ps

module gameControl (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  iniciar,
    input  gameCtrlPkg::statusBus status,
    input  gameDataPkg::keyEvent  key,
    output gameCtrlPkg::ctrlBus   ctrl,
    output logic                  showing,
    output logic                  playerTurn,
    output gameCtrlPkg::outcome   endCode,
    output gameCtrlPkg::gameState dbState
);

    gameCtrlPkg::gameState state;
    gameCtrlPkg::gameState nextState;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= gameCtrlPkg::idle;
        end else begin
            state <= nextState;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        nextState = state;
        unique case (state)
            gameCtrlPkg::idle: begin
                if (iniciar) begin
                    nextState = gameCtrlPkg::initGame;
                end
            end
            gameCtrlPkg::initGame:   nextState = gameCtrlPkg::roundStart;
            gameCtrlPkg::roundStart: nextState = gameCtrlPkg::showEntry;
            gameCtrlPkg::showEntry:  nextState = gameCtrlPkg::showWait;
            gameCtrlPkg::showWait: begin
                // Last entry of the round also gets its full show time
                if (status.showDone) begin
                    nextState = status.addrEqRound ? gameCtrlPkg::playStart
                                                   : gameCtrlPkg::showNext;
                end
            end
            gameCtrlPkg::showNext:   nextState = gameCtrlPkg::showEntry;
            gameCtrlPkg::playStart:  nextState = gameCtrlPkg::playWait;
            gameCtrlPkg::playWait: begin
                if (status.timedLevel && status.timeUp) begin
                    nextState = gameCtrlPkg::timedOut;
                end else if (key.valid) begin
                    nextState = gameCtrlPkg::latchPlay;
                end
            end
            gameCtrlPkg::latchPlay:  nextState = gameCtrlPkg::compare;
            gameCtrlPkg::compare: begin
                if (!status.playCorrect) begin
                    nextState = gameCtrlPkg::lost;
                end else if (!status.addrEqRound) begin
                    nextState = gameCtrlPkg::nextPlay;
                end else if (status.lastRound) begin
                    nextState = gameCtrlPkg::won;
                end else begin
                    nextState = gameCtrlPkg::nextRound;
                end
            end
            gameCtrlPkg::nextPlay:   nextState = gameCtrlPkg::playWait;
            gameCtrlPkg::nextRound:  nextState = gameCtrlPkg::roundStart;
            gameCtrlPkg::won,
            gameCtrlPkg::lost,
            gameCtrlPkg::timedOut: begin
                if (iniciar) begin
                    nextState = gameCtrlPkg::initGame;
                end
            end
            default:                 nextState = gameCtrlPkg::idle;
        endcase
    end

    // --------------------------------------------------
    // Moore outputs
    // --------------------------------------------------
    always_comb begin
        ctrl            = '0;
        ctrl.zeroPlay   = (state == gameCtrlPkg::idle);
        ctrl.loadLevel  = (state == gameCtrlPkg::initGame);
        ctrl.zeroRound  = (state == gameCtrlPkg::initGame);
        ctrl.zeroAddr   = (state == gameCtrlPkg::roundStart) || (state == gameCtrlPkg::playStart);
        ctrl.countAddr  = (state == gameCtrlPkg::showNext) || (state == gameCtrlPkg::nextPlay);
        ctrl.zeroShow   = (state == gameCtrlPkg::showEntry);
        ctrl.countShow  = (state == gameCtrlPkg::showWait);
        ctrl.countRound = (state == gameCtrlPkg::nextRound);
        ctrl.zeroTime   = (state == gameCtrlPkg::playStart) || (state == gameCtrlPkg::nextPlay);
        ctrl.countTime  = (state == gameCtrlPkg::playWait);
        ctrl.loadPlay   = (state == gameCtrlPkg::latchPlay);
    end

    assign showing    = (state == gameCtrlPkg::showEntry) || (state == gameCtrlPkg::showWait);
    assign playerTurn = (state == gameCtrlPkg::playWait);

    always_comb begin
        unique case (state)
            gameCtrlPkg::won:      endCode = gameCtrlPkg::win;
            gameCtrlPkg::lost:     endCode = gameCtrlPkg::loss;
            gameCtrlPkg::timedOut: endCode = gameCtrlPkg::timeout;
            default:               endCode = gameCtrlPkg::none;
        endcase
    end

    assign dbState = state;

endmodule

// File: logic/playDecode.sv
/*
 * Button decoder. Buttons must be clean and synchronous to clock.
 * An event fires one cycle after the buttons go from all released to
 * exactly one pressed; chords of two or more keys are ignored.
 */
`timescale 1ns/1ps

module playDecode (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [3:0]           buttons,
    output gameDataPkg::keyEvent key
);

    logic [3:0]          prevButtons;
    logic                oneHot;
    logic                pressEdge;
    gameDataPkg::keyCode pressedCode;

    // Exactly one bit set
    assign oneHot = (buttons != 4'b0000) && ((buttons & (buttons - 4'd1)) == 4'b0000);

    assign pressEdge = oneHot && (prevButtons == 4'b0000);

    always_comb begin
        unique case (buttons)
            4'b0010: pressedCode = 2'd1;
            4'b0100: pressedCode = 2'd2;
            4'b1000: pressedCode = 2'd3;
            default: pressedCode = 2'd0;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prevButtons <= 4'b0000;
            key         <= '0;
        end else begin
            prevButtons <= buttons;
            key.valid   <= pressEdge;
            // Code held so the FSM can still read it in latchPlay
            if (pressEdge) begin
                key.code <= pressedCode;
            end
        end
    end

endmodule

// File: logic/gameCtrlPkg.sv
/*
 * Controller types shared by the FSM, the datapath and the result stage.
 * State codes follow the debug encoding seen on dbState (0x0 to 0xF,
 * with 0xD unused).
 */
package gameCtrlPkg;

    // FSM states, value is what dbState shows
    typedef enum logic [3:0] {
        idle       = 4'h0,
        initGame   = 4'h1,
        roundStart = 4'h2,
        showEntry  = 4'h3,
        showWait   = 4'h4,
        showNext   = 4'h5,
        playStart  = 4'h6,
        playWait   = 4'h7,
        latchPlay  = 4'h8,
        compare    = 4'h9,
        won        = 4'hA,
        nextPlay   = 4'hB,
        nextRound  = 4'hC,
        lost       = 4'hE,
        timedOut   = 4'hF
    } gameState;

    // Commands from the FSM to the datapath
    typedef struct packed {
        logic zeroAddr;
        logic countAddr;
        logic zeroShow;
        logic countShow;
        logic zeroRound;
        logic countRound;
        logic zeroTime;
        logic countTime;
        logic loadPlay;
        logic zeroPlay;
        logic loadLevel;
    } ctrlBus;

    // Conditions from the datapath back to the FSM
    typedef struct packed {
        logic showDone;
        logic addrEqRound;
        logic lastRound;
        logic playCorrect;
        logic timeUp;
        logic timedLevel;
    } statusBus;

    typedef enum logic [1:0] {
        none    = 2'd0,
        win     = 2'd1,
        loss    = 2'd2,
        timeout = 2'd3
    } outcome;

endpackage

// File: logic/gameDataPkg.sv
/*
 * Data types of the game for key codes, the sequence index and key events.
 * The sequence holds at most 16 entries, so one 4-bit index serves as
 * both entry address and round number.
 */
package gameDataPkg;

    // Key index as used for the button and LED bits
    typedef logic [1:0] keyCode;

    // Sequence entry address and round number (0 to 15)
    typedef logic [3:0] seqAddr;

    // --------------------------------------------------
    // Key event from the button decoder
    // --------------------------------------------------
    // valid pulses for one cycle per press
    // code keeps the last pressed key between events
    typedef struct packed {
        logic   valid;
        keyCode code;
    } keyEvent;

endpackage
